// ==== common/dwc_pkg.sv ====
package dwc_pkg;

  // The address width is the same on both ports.
  localparam int unsigned ADDR_W = 16;

  // The slave port is twice as wide as the master port.
  localparam int unsigned SLV_DATA_W = 64;
  localparam int unsigned MST_DATA_W = 32;

  // Each strobe bit covers one byte lane.
  localparam int unsigned SLV_STRB_W = SLV_DATA_W / 8;
  localparam int unsigned MST_STRB_W = MST_DATA_W / 8;

  // Each slave beat becomes this many master beats.
  localparam int unsigned DOWNSIZE_FACTOR = SLV_DATA_W / MST_DATA_W;

  // The select counts master beats within one slave beat.
  localparam int unsigned SEL_W = $clog2(DOWNSIZE_FACTOR);

  // This address bit picks the half of the wide word that a master beat carries.
  localparam int unsigned SEL_OFFSET = $clog2(MST_STRB_W);

  typedef logic [SEL_W-1:0] sel_t;

  // Response codes are ORed across the beats of one transfer.
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [SLV_DATA_W-1:0] slv_data_t;
  typedef logic [MST_DATA_W-1:0] mst_data_t;
  typedef logic [SLV_STRB_W-1:0] slv_strb_t;
  typedef logic [MST_STRB_W-1:0] mst_strb_t;

  // AW and AR carry the same fields on both ports.
  typedef struct packed {
    addr_t      addr;
    logic [2:0] prot;
  } addr_chan_t;

  typedef struct packed {
    slv_data_t data;
    slv_strb_t strb;
  } slv_w_chan_t;

  typedef struct packed {
    mst_data_t data;
    mst_strb_t strb;
  } mst_w_chan_t;

  typedef struct packed {
    resp_t resp;
  } b_chan_t;

  typedef struct packed {
    mst_data_t data;
    resp_t     resp;
  } mst_r_chan_t;

  typedef struct packed {
    slv_data_t data;
    resp_t     resp;
  } slv_r_chan_t;

  // A wide data word, seen either whole or as master-sized halves.
  // Half 0 is the low half of the word.
  typedef union packed {
    slv_data_t                        word;
    mst_data_t [DOWNSIZE_FACTOR-1:0] half;
  } wide_data_u;

endpackage

// ==== downsizer/dwc_addr_split.sv ====
`timescale 1ns/1ps

module dwc_addr_split
  import dwc_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  addr_chan_t req_i,
  output logic       mst_valid_o,
  input  logic       mst_ready_i,
  output addr_chan_t mst_o
);

  // The counter names the master beat that is presented now.
  sel_t sel_q;
  logic last_beat;
  logic mst_hs;

  assign last_beat = (sel_q == sel_t'(DOWNSIZE_FACTOR - 1));
  assign mst_hs    = mst_valid_o & mst_ready_i;

  // Every beat of one request is offered while the spill entry is held.
  assign mst_valid_o = req_valid_i;

  // The entry is released only with the handshake of the last beat.
  assign req_ready_o = mst_ready_i & last_beat;

  // Each master beat is aligned to the master bus.
  // The half-select bits come from the counter, whatever the slave address held there.
  always_comb begin
    mst_o                               = req_i;
    mst_o.addr[SEL_OFFSET +: SEL_W]     = sel_q;
    mst_o.addr[SEL_OFFSET-1:0]          = '0;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sel_q <= '0;
    end else if (mst_hs) begin
      // The counter wraps after the last beat, ready for the next request.
      sel_q <= last_beat ? '0 : sel_t'(sel_q + 1'b1);
    end
  end

  // A stalled master beat must not change, which relies on the spill register
  // holding its entry until the last beat is accepted.
  stable_mst_a : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (mst_valid_o && !mst_ready_i) |=> (mst_valid_o && $stable(mst_o))
  ) else $error("Address beat changed while stalled.");

endmodule

// ==== downsizer/dwc_b_merge.sv ====
`timescale 1ns/1ps

module dwc_b_merge
  import dwc_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  input  logic    mst_valid_i,
  output logic    mst_ready_o,
  input  b_chan_t mst_i,
  output logic    slv_valid_o,
  input  logic    slv_ready_i,
  output b_chan_t slv_o
);

  // Counts master responses and keeps the OR of the ones already taken.
  sel_t  cnt_q;
  resp_t resp_q;
  logic  last_beat;
  logic  mst_hs;

  assign last_beat = (cnt_q == sel_t'(DOWNSIZE_FACTOR - 1));

  // Early responses are always swallowed.
  // The last one waits for the slave side.
  assign mst_ready_o = last_beat ? slv_ready_i : 1'b1;
  assign slv_valid_o = mst_valid_i & last_beat;
  assign mst_hs      = mst_valid_i & mst_ready_o;

  // An error in any half turns the whole write into an error.
  always_comb begin
    slv_o      = mst_i;
    slv_o.resp = mst_i.resp | resp_q;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q  <= '0;
      resp_q <= RESP_OKAY;
    end else if (mst_hs) begin
      cnt_q  <= last_beat ? '0 : sel_t'(cnt_q + 1'b1);
      // The accumulator starts over once the merged response is handed off.
      resp_q <= last_beat ? RESP_OKAY : (resp_q | mst_i.resp);
    end
  end

  // The merged response holds while the slave side stalls it.
  stable_slv_b : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (slv_valid_o && !slv_ready_i) |=> (slv_valid_o && $stable(slv_o))
  ) else $error("B response changed while stalled.");

endmodule

// ==== downsizer/dwc_r_merge.sv ====
`timescale 1ns/1ps

module dwc_r_merge
  import dwc_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        mst_valid_i,
  output logic        mst_ready_o,
  input  mst_r_chan_t mst_i,
  output logic        slv_valid_o,
  input  logic        slv_ready_i,
  output slv_r_chan_t slv_o
);

  // Only the first beat is stored.
  // The second one goes through to the slave side without a register.
  sel_t       cnt_q;
  mst_data_t  data_q;
  resp_t      resp_q;
  logic       last_beat;
  logic       mst_hs;
  wide_data_u r_wide;

  assign last_beat = (cnt_q == sel_t'(DOWNSIZE_FACTOR - 1));

  assign mst_ready_o = last_beat ? slv_ready_i : 1'b1;
  assign slv_valid_o = mst_valid_i & last_beat;
  assign mst_hs      = mst_valid_i & mst_ready_o;

  // Reads were issued low half first, so the stored beat is the low half.
  always_comb begin
    r_wide.half[0] = data_q;
    r_wide.half[1] = mst_i.data;
    slv_o.data     = r_wide.word;
    slv_o.resp     = resp_q | mst_i.resp;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q  <= '0;
      resp_q <= RESP_OKAY;
    end else if (mst_hs) begin
      cnt_q <= last_beat ? '0 : sel_t'(cnt_q + 1'b1);
      if (!last_beat) begin
        resp_q <= mst_i.resp;
      end
    end
  end

  // The first beat's data waits here until the second beat completes the word.
  always_ff @(posedge clk_i) begin
    if (mst_hs && !last_beat) begin
      data_q <= mst_i.data;
    end
  end

  // The joined beat holds while the slave side stalls it.
  stable_slv_r : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (slv_valid_o && !slv_ready_i) |=> (slv_valid_o && $stable(slv_o))
  ) else $error("R beat changed while stalled.");

endmodule

// ==== downsizer/dwc_w_split.sv ====
`timescale 1ns/1ps

module dwc_w_split
  import dwc_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        req_valid_i,
  output logic        req_ready_o,
  input  slv_w_chan_t req_i,
  output logic        mst_valid_o,
  input  logic        mst_ready_i,
  output mst_w_chan_t mst_o
);

  // This counter runs on its own and is not tied to the AW split.
  // Both see the same order of beats, so they stay in step.
  sel_t       sel_q;
  logic       last_beat;
  logic       mst_hs;
  wide_data_u w_wide;

  assign last_beat = (sel_q == sel_t'(DOWNSIZE_FACTOR - 1));
  assign mst_hs    = mst_valid_o & mst_ready_i;

  assign mst_valid_o = req_valid_i;
  assign req_ready_o = mst_ready_i & last_beat;

  // The wide word is cut into halves.
  // Beat 0 carries the low half with the low strobe bits.
  always_comb begin
    w_wide.word = req_i.data;
    mst_o.data  = w_wide.half[sel_q];
    mst_o.strb  = req_i.strb[sel_q*MST_STRB_W +: MST_STRB_W];
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sel_q <= '0;
    end else if (mst_hs) begin
      sel_q <= last_beat ? '0 : sel_t'(sel_q + 1'b1);
    end
  end

  // The half on offer stays put until the master takes it.
  stable_mst_w : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (mst_valid_o && !mst_ready_i) |=> (mst_valid_o && $stable(mst_o))
  ) else $error("W beat changed while stalled.");

endmodule

// ==== hw/dwc_spill_reg.sv ====
`timescale 1ns/1ps

module dwc_spill_reg #(
  parameter int unsigned WIDTH = 8
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [WIDTH-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [WIDTH-1:0] data_o
);

  // Entry A drives the output.
  // Entry B catches a beat that arrives while A is stalled.
  // Both valid and ready come straight from flops, so no combinational path crosses the slice.
  logic             a_full_q;
  logic             b_full_q;
  logic [WIDTH-1:0] a_data_q;
  logic [WIDTH-1:0] b_data_q;
  logic             push;
  logic             pop;
  logic             a_load;
  logic             b_load;

  // New beats are taken as long as the skid entry is free.
  assign ready_o = ~b_full_q;
  assign valid_o = a_full_q;
  assign data_o  = a_data_q;

  assign push = valid_i & ready_o;
  assign pop  = a_full_q & ready_i;

  // A refills when it is empty or being drained, taking the older B entry first.
  assign a_load = (~a_full_q | pop) & (b_full_q | push);

  // A beat goes to B only when A is full and stays full this cycle.
  assign b_load = push & a_full_q & ~pop;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= a_load | (a_full_q & ~pop);
      b_full_q <= b_load | (b_full_q & ~pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_load) begin
      a_data_q <= b_full_q ? b_data_q : data_i;
    end
    if (b_load) begin
      b_data_q <= data_i;
    end
  end

endmodule

// ==== hw/dwc_top.sv ====
`timescale 1ns/1ps

module dwc_top
  import dwc_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        slv_aw_valid_i,
  output logic        slv_aw_ready_o,
  input  addr_chan_t  slv_aw_i,
  input  logic        slv_w_valid_i,
  output logic        slv_w_ready_o,
  input  slv_w_chan_t slv_w_i,
  output logic        slv_b_valid_o,
  input  logic        slv_b_ready_i,
  output b_chan_t     slv_b_o,
  input  logic        slv_ar_valid_i,
  output logic        slv_ar_ready_o,
  input  addr_chan_t  slv_ar_i,
  output logic        slv_r_valid_o,
  input  logic        slv_r_ready_i,
  output slv_r_chan_t slv_r_o,
  output logic        mst_aw_valid_o,
  input  logic        mst_aw_ready_i,
  output addr_chan_t  mst_aw_o,
  output logic        mst_w_valid_o,
  input  logic        mst_w_ready_i,
  output mst_w_chan_t mst_w_o,
  input  logic        mst_b_valid_i,
  output logic        mst_b_ready_o,
  input  b_chan_t     mst_b_i,
  output logic        mst_ar_valid_o,
  input  logic        mst_ar_ready_i,
  output addr_chan_t  mst_ar_o,
  input  logic        mst_r_valid_i,
  output logic        mst_r_ready_o,
  input  mst_r_chan_t mst_r_i
);

  // Slave requests are registered first, so the splitters see stable entries.
  addr_chan_t  aw_spill;
  logic        aw_spill_valid;
  logic        aw_spill_ready;
  slv_w_chan_t w_spill;
  logic        w_spill_valid;
  logic        w_spill_ready;
  addr_chan_t  ar_spill;
  logic        ar_spill_valid;
  logic        ar_spill_ready;

  dwc_spill_reg #(.WIDTH($bits(addr_chan_t))) i_spill_aw (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (slv_aw_valid_i),
    .ready_o (slv_aw_ready_o),
    .data_i  (slv_aw_i),
    .valid_o (aw_spill_valid),
    .ready_i (aw_spill_ready),
    .data_o  (aw_spill)
  );

  dwc_spill_reg #(.WIDTH($bits(slv_w_chan_t))) i_spill_w (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (slv_w_valid_i),
    .ready_o (slv_w_ready_o),
    .data_i  (slv_w_i),
    .valid_o (w_spill_valid),
    .ready_i (w_spill_ready),
    .data_o  (w_spill)
  );

  dwc_spill_reg #(.WIDTH($bits(addr_chan_t))) i_spill_ar (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (slv_ar_valid_i),
    .ready_o (slv_ar_ready_o),
    .data_i  (slv_ar_i),
    .valid_o (ar_spill_valid),
    .ready_i (ar_spill_ready),
    .data_o  (ar_spill)
  );

  // The write address and the read address are split in the same way.
  dwc_addr_split i_aw_split (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_valid_i (aw_spill_valid),
    .req_ready_o (aw_spill_ready),
    .req_i       (aw_spill),
    .mst_valid_o (mst_aw_valid_o),
    .mst_ready_i (mst_aw_ready_i),
    .mst_o       (mst_aw_o)
  );

  dwc_addr_split i_ar_split (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_valid_i (ar_spill_valid),
    .req_ready_o (ar_spill_ready),
    .req_i       (ar_spill),
    .mst_valid_o (mst_ar_valid_o),
    .mst_ready_i (mst_ar_ready_i),
    .mst_o       (mst_ar_o)
  );

  dwc_w_split i_w_split (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_valid_i (w_spill_valid),
    .req_ready_o (w_spill_ready),
    .req_i       (w_spill),
    .mst_valid_o (mst_w_valid_o),
    .mst_ready_i (mst_w_ready_i),
    .mst_o       (mst_w_o)
  );

  // Responses come back without a spill register.
  // The last beat passes straight through.
  dwc_b_merge i_b_merge (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .mst_valid_i (mst_b_valid_i),
    .mst_ready_o (mst_b_ready_o),
    .mst_i       (mst_b_i),
    .slv_valid_o (slv_b_valid_o),
    .slv_ready_i (slv_b_ready_i),
    .slv_o       (slv_b_o)
  );

  dwc_r_merge i_r_merge (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .mst_valid_i (mst_r_valid_i),
    .mst_ready_o (mst_r_ready_o),
    .mst_i       (mst_r_i),
    .slv_valid_o (slv_r_valid_o),
    .slv_ready_i (slv_r_ready_i),
    .slv_o       (slv_r_o)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds the downsizer testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_dwc -f sources.f -o tb_dwc \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_dwc > sim.log 2>&1 || echo "=== FAIL ===" >> sim.log
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "Simulation failed"; exit 1; } \
  || { echo "Simulation passed"; exit 0; }

// ==== sources.f ====
common/dwc_pkg.sv
hw/dwc_spill_reg.sv
downsizer/dwc_addr_split.sv
downsizer/dwc_w_split.sv
downsizer/dwc_b_merge.sv
downsizer/dwc_r_merge.sv
hw/dwc_top.sv
tests/tb_dwc.sv

// ==== tests/tb_dwc.sv ====
`timescale 1ns/1ps

module tb_dwc
  import dwc_pkg::*;
();

  // The run ends here even if a handshake never completes.
  // About 150 transactions at up to 20 cycles each fit well below this limit.
  localparam int unsigned CYCLE_LIMIT = 4000;
  localparam int unsigned MEM_WORDS   = 2 ** (ADDR_W - 2);
  localparam addr_t       ERR_ADDR    = 16'h00F4;

  logic clk = 1'b0;
  logic reset;
  logic timed_out = 1'b0;

  logic slv_aw_valid, slv_aw_ready, slv_w_valid, slv_w_ready, slv_b_valid, slv_b_ready;
  logic slv_ar_valid, slv_ar_ready, slv_r_valid, slv_r_ready;
  logic mst_aw_valid, mst_aw_ready, mst_w_valid, mst_w_ready, mst_b_valid, mst_b_ready;
  logic mst_ar_valid, mst_ar_ready, mst_r_valid, mst_r_ready;
  addr_chan_t  slv_aw, slv_ar, mst_aw, mst_ar;
  slv_w_chan_t slv_w;
  mst_w_chan_t mst_w;
  b_chan_t     slv_b, mst_b;
  slv_r_chan_t slv_r;
  mst_r_chan_t mst_r;

  // Slave requests wait here until the driver can put them on the bus.
  addr_chan_t  drv_aw_q[$];
  slv_w_chan_t drv_w_q[$];
  addr_chan_t  drv_ar_q[$];
  // Expected master beats and slave responses, in bus order.
  addr_chan_t  exp_aw_q[$];
  mst_w_chan_t exp_w_q[$];
  addr_chan_t  exp_ar_q[$];
  b_chan_t     exp_b_q[$];
  slv_r_chan_t exp_r_q[$];
  // The memory model pairs accepted AW and W beats and queues its answers.
  addr_chan_t  mem_aw_q[$];
  mst_w_chan_t mem_w_q[$];
  addr_chan_t  mem_ar_q[$];
  b_chan_t     b_pend_q[$];
  mst_r_chan_t r_pend_q[$];

  // The memory seen by the DUT and the copy that predicts it.
  logic [MST_DATA_W-1:0] mem    [MEM_WORDS];
  logic [MST_DATA_W-1:0] shadow [MEM_WORDS];

  string test_name;
  logic  bp_en;
  int    addr_errs, w_errs, b_errs, r_errs, other_errs;

  always #20 clk = ~clk;

  dwc_top dut_i (
    .clk_i          (clk),
    .reset_i        (reset),
    .slv_aw_valid_i (slv_aw_valid),
    .slv_aw_ready_o (slv_aw_ready),
    .slv_aw_i       (slv_aw),
    .slv_w_valid_i  (slv_w_valid),
    .slv_w_ready_o  (slv_w_ready),
    .slv_w_i        (slv_w),
    .slv_b_valid_o  (slv_b_valid),
    .slv_b_ready_i  (slv_b_ready),
    .slv_b_o        (slv_b),
    .slv_ar_valid_i (slv_ar_valid),
    .slv_ar_ready_o (slv_ar_ready),
    .slv_ar_i       (slv_ar),
    .slv_r_valid_o  (slv_r_valid),
    .slv_r_ready_i  (slv_r_ready),
    .slv_r_o        (slv_r),
    .mst_aw_valid_o (mst_aw_valid),
    .mst_aw_ready_i (mst_aw_ready),
    .mst_aw_o       (mst_aw),
    .mst_w_valid_o  (mst_w_valid),
    .mst_w_ready_i  (mst_w_ready),
    .mst_w_o        (mst_w),
    .mst_b_valid_i  (mst_b_valid),
    .mst_b_ready_o  (mst_b_ready),
    .mst_b_i        (mst_b),
    .mst_ar_valid_o (mst_ar_valid),
    .mst_ar_ready_i (mst_ar_ready),
    .mst_ar_o       (mst_ar),
    .mst_r_valid_i  (mst_r_valid),
    .mst_r_ready_o  (mst_r_ready),
    .mst_r_i        (mst_r)
  );

  // Each word starts as its own byte address next to the inverted address.
  function automatic logic [MST_DATA_W-1:0] fill_word(int unsigned idx);
    addr_t a;
    a = addr_t'(idx << 2);
    return {~a, a};
  endfunction

  // Only the one error address answers SLVERR.
  function automatic resp_t access_resp(addr_t addr);
    return (addr == ERR_ADDR) ? RESP_SLVERR : RESP_OKAY;
  endfunction

  // A master beat goes to the aligned word of its half of the 64-bit location.
  function automatic addr_chan_t split_addr(addr_chan_t req, int unsigned beat);
    addr_chan_t m;
    m      = req;
    m.addr = {req.addr[ADDR_W-1:3], beat[0], 2'b00};
    return m;
  endfunction

  // Beat 0 carries the low half and the low four strobes, beat 1 the rest.
  function automatic mst_w_chan_t split_w(slv_w_chan_t w, int unsigned beat);
    wide_data_u  u;
    mst_w_chan_t m;
    u.word = w.data;
    m.data = u.half[beat];
    m.strb = (beat == 0) ? w.strb[3:0] : w.strb[7:4];
    return m;
  endfunction

  function automatic logic [MST_DATA_W-1:0] merge_bytes(logic [MST_DATA_W-1:0] old,
                                                        mst_w_chan_t w);
    logic [MST_DATA_W-1:0] r;
    r = old;
    for (int b = 0; b < MST_STRB_W; b++) begin
      if (w.strb[b]) r[8*b +: 8] = w.data[8*b +: 8];
    end
    return r;
  endfunction

  // The slave sees both halves joined, with an error in either half ORed in.
  function automatic slv_r_chan_t expect_read(addr_chan_t req);
    wide_data_u  u;
    slv_r_chan_t r;
    addr_chan_t  m;
    r.resp = RESP_OKAY;
    for (int unsigned b = 0; b < DOWNSIZE_FACTOR; b++) begin
      m         = split_addr(req, b);
      u.half[b] = shadow[m.addr[ADDR_W-1:2]];
      r.resp    = r.resp | access_resp(m.addr);
    end
    r.data = u.word;
    return r;
  endfunction

  task automatic check_addr(string name, addr_chan_t exp, addr_chan_t act);
    if (act !== exp) begin
      addr_errs++;
      $display("ERR %s: expected addr %h prot %h, actual addr %h prot %h",
               name, exp.addr, exp.prot, act.addr, act.prot);
    end
  endtask

  task automatic check_w(string name, mst_w_chan_t exp, mst_w_chan_t act);
    if (act !== exp) begin
      w_errs++;
      $display("ERR %s: expected data %h strb %h, actual data %h strb %h",
               name, exp.data, exp.strb, act.data, act.strb);
    end
  endtask

  task automatic check_b(string name, b_chan_t exp, b_chan_t act);
    if (act !== exp) begin
      b_errs++;
      $display("ERR %s: expected resp %h, actual resp %h", name, exp.resp, act.resp);
    end
  endtask

  task automatic check_r(string name, slv_r_chan_t exp, slv_r_chan_t act);
    if (act !== exp) begin
      r_errs++;
      $display("ERR %s: expected data %h resp %h, actual data %h resp %h",
               name, exp.data, exp.resp, act.data, act.resp);
    end
  endtask

  task automatic report_unexpected(string what);
    other_errs++;
    $display("In test %s a %s arrived when none was expected.", test_name, what);
  endtask

  // Queues one slave write and everything that it should cause.
  task automatic queue_write(addr_t addr, slv_w_chan_t w, logic [2:0] prot);
    addr_chan_t  req;
    addr_chan_t  ma;
    mst_w_chan_t mw;
    b_chan_t     b;
    req.addr = addr;
    req.prot = prot;
    b.resp   = RESP_OKAY;
    drv_aw_q.push_back(req);
    drv_w_q.push_back(w);
    for (int unsigned beat = 0; beat < DOWNSIZE_FACTOR; beat++) begin
      ma = split_addr(req, beat);
      mw = split_w(w, beat);
      exp_aw_q.push_back(ma);
      exp_w_q.push_back(mw);
      shadow[ma.addr[ADDR_W-1:2]] = merge_bytes(shadow[ma.addr[ADDR_W-1:2]], mw);
      b.resp = b.resp | access_resp(ma.addr);
    end
    exp_b_q.push_back(b);
  endtask

  // The example write to the first location has fixed master beats.
  // They stand in for the computed ones, so the DUT is held to the known values.
  task automatic expect_example_beats(logic [2:0] prot);
    addr_chan_t  a;
    mst_w_chan_t d;
    exp_aw_q.delete();
    exp_w_q.delete();
    a.prot = prot;
    a.addr = 16'h0000;
    exp_aw_q.push_back(a);
    a.addr = 16'h0004;
    exp_aw_q.push_back(a);
    d.data = 32'hAAAABBBB;
    d.strb = 4'hB;
    exp_w_q.push_back(d);
    d.data = 32'hBEEFBEEF;
    d.strb = 4'hA;
    exp_w_q.push_back(d);
  endtask

  task automatic queue_read(addr_t addr, logic [2:0] prot);
    addr_chan_t req;
    req.addr = addr;
    req.prot = prot;
    drv_ar_q.push_back(req);
    for (int unsigned beat = 0; beat < DOWNSIZE_FACTOR; beat++) begin
      exp_ar_q.push_back(split_addr(req, beat));
    end
    exp_r_q.push_back(expect_read(req));
  endtask

  // Handshakes are sampled at the falling edge, where every signal has settled.
  // New values go out 2 ns after the rising edge that completed them.
  task automatic run_cycle();
    logic        s_aw_hs, s_w_hs, s_ar_hs, s_b_hs, s_r_hs;
    logic        m_aw_hs, m_w_hs, m_ar_hs, m_b_hs, m_r_hs;
    addr_chan_t  wa;
    mst_w_chan_t wd;
    b_chan_t     nb;
    mst_r_chan_t nr;
    @(negedge clk);
    s_aw_hs = slv_aw_valid & slv_aw_ready;
    s_w_hs  = slv_w_valid & slv_w_ready;
    s_ar_hs = slv_ar_valid & slv_ar_ready;
    s_b_hs  = slv_b_valid & slv_b_ready;
    s_r_hs  = slv_r_valid & slv_r_ready;
    m_aw_hs = mst_aw_valid & mst_aw_ready;
    m_w_hs  = mst_w_valid & mst_w_ready;
    m_ar_hs = mst_ar_valid & mst_ar_ready;
    m_b_hs  = mst_b_valid & mst_b_ready;
    m_r_hs  = mst_r_valid & mst_r_ready;
    if (m_aw_hs) begin
      if (exp_aw_q.size() == 0) report_unexpected("master AW beat");
      else check_addr({test_name, " AW"}, exp_aw_q.pop_front(), mst_aw);
      mem_aw_q.push_back(mst_aw);
    end
    if (m_w_hs) begin
      if (exp_w_q.size() == 0) report_unexpected("master W beat");
      else check_w({test_name, " W"}, exp_w_q.pop_front(), mst_w);
      mem_w_q.push_back(mst_w);
    end
    if (m_ar_hs) begin
      if (exp_ar_q.size() == 0) report_unexpected("master AR beat");
      else check_addr({test_name, " AR"}, exp_ar_q.pop_front(), mst_ar);
      mem_ar_q.push_back(mst_ar);
    end
    if (s_b_hs) begin
      if (exp_b_q.size() == 0) report_unexpected("slave B response");
      else check_b({test_name, " B"}, exp_b_q.pop_front(), slv_b);
    end
    if (s_r_hs) begin
      if (exp_r_q.size() == 0) report_unexpected("slave R beat");
      else check_r({test_name, " R"}, exp_r_q.pop_front(), slv_r);
    end
    @(posedge clk);
    #2;
    // A slave valid drops only after its handshake.
    if (s_aw_hs) slv_aw_valid = 1'b0;
    if (!slv_aw_valid && drv_aw_q.size() > 0) begin
      slv_aw       = drv_aw_q.pop_front();
      slv_aw_valid = 1'b1;
    end
    if (s_w_hs) slv_w_valid = 1'b0;
    if (!slv_w_valid && drv_w_q.size() > 0) begin
      slv_w       = drv_w_q.pop_front();
      slv_w_valid = 1'b1;
    end
    if (s_ar_hs) slv_ar_valid = 1'b0;
    if (!slv_ar_valid && drv_ar_q.size() > 0) begin
      slv_ar       = drv_ar_q.pop_front();
      slv_ar_valid = 1'b1;
    end
    // The memory commits a write once it holds both its address and its data.
    while (mem_aw_q.size() > 0 && mem_w_q.size() > 0) begin
      wa = mem_aw_q.pop_front();
      wd = mem_w_q.pop_front();
      mem[wa.addr[ADDR_W-1:2]] = merge_bytes(mem[wa.addr[ADDR_W-1:2]], wd);
      nb.resp = access_resp(wa.addr);
      b_pend_q.push_back(nb);
    end
    while (mem_ar_q.size() > 0) begin
      wa      = mem_ar_q.pop_front();
      nr.data = mem[wa.addr[ADDR_W-1:2]];
      nr.resp = access_resp(wa.addr);
      r_pend_q.push_back(nr);
    end
    if (m_b_hs) mst_b_valid = 1'b0;
    if (!mst_b_valid && b_pend_q.size() > 0) begin
      mst_b       = b_pend_q.pop_front();
      mst_b_valid = 1'b1;
    end
    if (m_r_hs) mst_r_valid = 1'b0;
    if (!mst_r_valid && r_pend_q.size() > 0) begin
      mst_r       = r_pend_q.pop_front();
      mst_r_valid = 1'b1;
    end
    // With back-pressure on, each ready is high about three cycles in four.
    mst_aw_ready = !bp_en || ($urandom_range(0, 3) != 0);
    mst_w_ready  = !bp_en || ($urandom_range(0, 3) != 0);
    mst_ar_ready = !bp_en || ($urandom_range(0, 3) != 0);
    slv_b_ready  = !bp_en || ($urandom_range(0, 3) != 0);
    slv_r_ready  = !bp_en || ($urandom_range(0, 3) != 0);
  endtask

  function automatic logic all_done();
    return drv_aw_q.size() == 0 && drv_w_q.size() == 0 && drv_ar_q.size() == 0 &&
           exp_aw_q.size() == 0 && exp_w_q.size() == 0 && exp_ar_q.size() == 0 &&
           exp_b_q.size() == 0 && exp_r_q.size() == 0;
  endfunction

  task automatic wait_idle();
    while (!all_done()) run_cycle();
  endtask

  task automatic check_idle_outputs();
    @(negedge clk);
    if (slv_b_valid || slv_r_valid || mst_aw_valid || mst_w_valid || mst_ar_valid) begin
      other_errs++;
      $display("After reset a valid output of the DUT is high without any request.");
    end
    @(posedge clk);
    #2;
  endtask

  // Random addresses cluster now and then around the error word.
  function automatic addr_t rand_addr();
    if ($urandom_range(0, 5) == 0) return 16'h00F0 | addr_t'($urandom_range(0, 7));
    return addr_t'($urandom_range(0, 511));
  endfunction

  task automatic finish_run();
    int total;
    total = addr_errs + w_errs + b_errs + r_errs + other_errs + int'(timed_out);
    $display("Errors: addr %0d, w %0d, b %0d, r %0d, other %0d, timeout %0d",
             addr_errs, w_errs, b_errs, r_errs, other_errs, int'(timed_out));
    if (total == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  initial begin : watchdog
    int unsigned cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles.", CYCLE_LIMIT);
    timed_out = 1'b1;
    finish_run();
  end

  initial begin : main
    slv_w_chan_t w;
    reset        = 1'b1;
    slv_aw_valid = 1'b0;
    slv_w_valid  = 1'b0;
    slv_ar_valid = 1'b0;
    slv_aw       = '0;
    slv_w        = '0;
    slv_ar       = '0;
    slv_b_ready  = 1'b1;
    slv_r_ready  = 1'b1;
    mst_aw_ready = 1'b1;
    mst_w_ready  = 1'b1;
    mst_ar_ready = 1'b1;
    mst_b_valid  = 1'b0;
    mst_r_valid  = 1'b0;
    mst_b        = '0;
    mst_r        = '0;
    bp_en        = 1'b0;
    addr_errs    = 0;
    w_errs       = 0;
    b_errs       = 0;
    r_errs       = 0;
    other_errs   = 0;
    void'($urandom(32'h2db0));
    for (int unsigned i = 0; i < MEM_WORDS; i++) begin
      mem[i]    = fill_word(i);
      shadow[i] = fill_word(i);
    end
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;

    test_name = "reset_idle";
    repeat (3) check_idle_outputs();

    // The split of the example write is known beat by beat.
    test_name = "write_split";
    w.data    = 64'hBEEFBEEFAAAABBBB;
    w.strb    = 8'hAB;
    queue_write(16'h0000, w, 3'b000);
    expect_example_beats(3'b000);
    wait_idle();
    queue_write(16'h0005, w, 3'b010);
    expect_example_beats(3'b010);
    wait_idle();

    test_name = "read_back";
    queue_read(16'h0000, 3'b000);
    queue_read(16'h0008, 3'b001);
    wait_idle();

    // Only the location that holds the error word answers SLVERR.
    test_name = "error_window";
    w.data    = 64'h0123456789ABCDEF;
    w.strb    = 8'hFF;
    queue_write(16'h00F0, w, 3'b000);
    queue_write(16'h00E8, w, 3'b000);
    queue_write(16'h00F8, w, 3'b000);
    wait_idle();
    queue_read(16'h00F0, 3'b000);
    queue_read(16'h00E8, 3'b000);
    queue_read(16'h00F8, 3'b000);
    wait_idle();

    // Reads start only after the writes before them have drained.
    test_name = "random";
    bp_en     = 1'b1;
    for (int round = 0; round < 10; round++) begin
      for (int k = 0; k < 5; k++) begin
        w.data = {$urandom, $urandom};
        w.strb = slv_strb_t'($urandom);
        queue_write(rand_addr(), w, 3'($urandom));
      end
      wait_idle();
      for (int k = 0; k < 5; k++) begin
        queue_read(rand_addr(), 3'($urandom));
      end
      wait_idle();
    end

    finish_run();
  end

endmodule
